// File: common/mk14_pkg.sv
// Shared boot types and memory map; every region base must be aligned to its own size
package mk14_pkg;

	// Boot sequencing states
	typedef enum logic [2:0] {
		BOOT_INIT,
		BOOT_RX_WAIT,
		BOOT_START,
		BOOT_RUNNING,
		BOOT_LOAD_ERROR
	} boot_state_t;

	// Loader error codes, held by the parser until soft reset
	typedef enum logic [1:0] {
		HEX_NONE,
		HEX_BAD_CHAR,
		HEX_BAD_CHECKSUM,
		HEX_BAD_TYPE
	} hex_error_t;

	// Monitor ROM
	localparam logic [11:0] ROM_BASE = 12'h000;
	localparam logic [11:0] ROM_SIZE = 12'd512;

	// Extended RAM
	localparam logic [11:0] EXT_RAM_BASE = 12'hB00;
	localparam logic [11:0] EXT_RAM_SIZE = 12'd256;

	// Standard RAM
	localparam logic [11:0] STD_RAM_BASE = 12'hF00;
	localparam logic [11:0] STD_RAM_SIZE = 12'd256;

	// Read value for any address outside the three regions
	localparam logic [7:0] UNMAPPED_DATA = 8'hFF;

endpackage

// File: source/uart_rx.sv
// 8N1 receiver; CLKS_PER_BIT must be at least 4, and a frame with a low stop bit is dropped
`timescale 1ns/1ns

module uart_rx #(
	parameter int CLKS_PER_BIT = 434
) (
	input  logic       clk,
	input  logic       soft_reset,
	input  logic       i_rx,
	output logic [7:0] o_rx_data,
	output logic       o_rx_valid
);

	localparam int CW = $clog2(CLKS_PER_BIT);
	// The synchronizer and start detect already cost about two cycles of the half bit
	localparam int HALF_WAIT = (CLKS_PER_BIT / 2 > 2) ? CLKS_PER_BIT / 2 - 2 : 0;
	localparam logic [CW-1:0] HALF_LAST = CW'(HALF_WAIT);
	localparam logic [CW-1:0] BIT_LAST = CW'(CLKS_PER_BIT - 1);

	typedef enum logic [1:0] {
		S_IDLE,
		S_START,
		S_DATA,
		S_STOP
	} rx_state_t;

	rx_state_t rx_state;
	logic rx_meta;
	logic rx_sync;
	logic [CW-1:0] clk_cnt;
	logic [2:0] bit_idx;
	logic [7:0] shift_reg;

	always_ff @(posedge clk) begin
		rx_meta <= i_rx;
		rx_sync <= rx_meta;
	end

	always_ff @(posedge clk) begin
		o_rx_valid <= 1'b0;
		if (soft_reset) begin
			rx_state <= S_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
		end else begin
			case (rx_state)
				S_IDLE: begin
					clk_cnt <= '0;
					if (!rx_sync)
						rx_state <= S_START;
				end
				S_START: begin
					if (clk_cnt == HALF_LAST) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						// A glitch that is gone by mid start bit is not a frame
						rx_state <= rx_sync ? S_IDLE : S_DATA;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				S_DATA: begin
					if (clk_cnt == BIT_LAST) begin
						clk_cnt <= '0;
						shift_reg <= {rx_sync, shift_reg[7:1]};
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							rx_state <= S_STOP;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				S_STOP: begin
					if (clk_cnt == BIT_LAST) begin
						clk_cnt <= '0;
						o_rx_valid <= rx_sync;
						rx_state <= S_IDLE;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: rx_state <= S_IDLE;
			endcase
		end
	end

	assign o_rx_data = shift_reg;

endmodule

// File: intel_hex/intel_hex.sv
// Intel HEX parser for types 00 and 01 only; addresses wrap to 12 bits and any error halts it until soft reset
`timescale 1ns/1ns

module intel_hex
	import mk14_pkg::*;
(
	input  logic        clk,
	input  logic        soft_reset,
	input  logic        i_en,
	input  logic [7:0]  i_data,
	output logic [11:0] o_wr_addr,
	output logic [7:0]  o_wr_data,
	output logic        o_wr_valid,
	output logic        o_parse_complete,
	output hex_error_t  o_error,
	output logic        o_idle
);

	typedef enum logic [2:0] {
		F_COLON,
		F_COUNT,
		F_ADDR,
		F_TYPE,
		F_DATA,
		F_CHECKSUM,
		F_ERROR
	} field_t;

	field_t fstate;
	logic low_digit;
	logic [3:0] hi_nib;
	logic addr_lo;
	logic [7:0] rec_cnt;
	logic [7:0] rec_idx;
	logic [11:0] rec_addr;
	logic rec_eof;
	logic [7:0] sum;

	logic [4:0] digit;
	logic [7:0] byte_val;

	// Bit 4 flags a valid hex digit, bits 3:0 hold its value
	function automatic logic [4:0] hex_digit(input logic [7:0] c);
		if (c >= "0" && c <= "9")
			return {1'b1, 4'(c - "0")};
		else if (c >= "A" && c <= "F")
			return {1'b1, 4'(c - "A" + 8'd10)};
		else if (c >= "a" && c <= "f")
			return {1'b1, 4'(c - "a" + 8'd10)};
		else
			return 5'b0;
	endfunction

	assign digit = hex_digit(i_data);
	assign byte_val = {hi_nib, digit[3:0]};
	assign o_idle = (fstate == F_COLON);

	always_ff @(posedge clk) begin
		o_wr_valid <= 1'b0;
		o_parse_complete <= 1'b0;
		if (soft_reset) begin
			fstate <= F_COLON;
			low_digit <= 1'b0;
			o_error <= HEX_NONE;
		end else if (i_en) begin
			case (fstate)
				F_COLON: begin
					low_digit <= 1'b0;
					if (i_data == ":") begin
						fstate <= F_COUNT;
					end else if (i_data != 8'h0D && i_data != 8'h0A) begin
						o_error <= HEX_BAD_CHAR;
						fstate <= F_ERROR;
					end
				end
				F_ERROR: begin
					fstate <= F_ERROR;
				end
				default: begin
					if (!digit[4]) begin
						o_error <= HEX_BAD_CHAR;
						fstate <= F_ERROR;
					end else if (!low_digit) begin
						hi_nib <= digit[3:0];
						low_digit <= 1'b1;
					end else begin
						low_digit <= 1'b0;
						sum <= sum + byte_val;
						case (fstate)
							F_COUNT: begin
								rec_cnt <= byte_val;
								sum <= byte_val;
								addr_lo <= 1'b0;
								fstate <= F_ADDR;
							end
							F_ADDR: begin
								addr_lo <= 1'b1;
								if (!addr_lo) begin
									rec_addr[11:8] <= byte_val[3:0];
								end else begin
									rec_addr[7:0] <= byte_val;
									fstate <= F_TYPE;
								end
							end
							F_TYPE: begin
								rec_idx <= '0;
								rec_eof <= (byte_val == 8'h01);
								if (byte_val > 8'h01) begin
									o_error <= HEX_BAD_TYPE;
									fstate <= F_ERROR;
								end else begin
									fstate <= (rec_cnt == 8'd0) ? F_CHECKSUM : F_DATA;
								end
							end
							F_DATA: begin
								// Payload of an end-of-file record is summed but never written
								o_wr_valid <= !rec_eof;
								o_wr_addr <= rec_addr + {4'h0, rec_idx};
								o_wr_data <= byte_val;
								rec_idx <= rec_idx + 1'b1;
								if (rec_idx == rec_cnt - 8'd1)
									fstate <= F_CHECKSUM;
							end
							default: begin
								if (sum + byte_val != 8'd0) begin
									o_error <= HEX_BAD_CHECKSUM;
									fstate <= F_ERROR;
								end else begin
									o_parse_complete <= rec_eof;
									fstate <= F_COLON;
								end
							end
						endcase
					end
				end
			endcase
		end
	end

endmodule

// File: source/memory_map.sv
// ROM and two RAMs with registered reads; the loader owns the write port while i_loading is high
`timescale 1ns/1ns

module memory_map
	import mk14_pkg::*;
(
	input  logic        clk,
	input  logic        i_loading,
	input  logic [11:0] i_load_addr,
	input  logic [7:0]  i_load_data,
	input  logic        i_load_wr,
	input  logic [11:0] i_core_addr,
	input  logic        i_core_wr_en,
	input  logic [7:0]  i_core_wr_data,
	input  logic [11:0] i_dbg_addr,
	output logic [7:0]  o_core_rd_data,
	output logic [7:0]  o_dbg_rd_data
);

	localparam int ROM_AW = $clog2(ROM_SIZE);
	localparam int EXT_AW = $clog2(EXT_RAM_SIZE);
	localparam int STD_AW = $clog2(STD_RAM_SIZE);

	logic [7:0] rom [0:ROM_SIZE-1];
	logic [7:0] ext_ram [0:EXT_RAM_SIZE-1];
	logic [7:0] std_ram [0:STD_RAM_SIZE-1];

	logic wr_en;
	logic [11:0] wr_addr;
	logic [7:0] wr_data;

	// Bases are size aligned, so masking off the offset bits decodes a region
	function automatic logic in_region(input logic [11:0] addr, input logic [11:0] base,
			input logic [11:0] size);
		return (addr & ~(size - 12'd1)) == base;
	endfunction

	function automatic logic [7:0] read_byte(input logic [11:0] addr);
		if (in_region(addr, ROM_BASE, ROM_SIZE))
			return rom[addr[ROM_AW-1:0]];
		else if (in_region(addr, EXT_RAM_BASE, EXT_RAM_SIZE))
			return ext_ram[addr[EXT_AW-1:0]];
		else if (in_region(addr, STD_RAM_BASE, STD_RAM_SIZE))
			return std_ram[addr[STD_AW-1:0]];
		else
			return UNMAPPED_DATA;
	endfunction

	assign wr_en = i_loading ? i_load_wr : i_core_wr_en;
	assign wr_addr = i_loading ? i_load_addr : i_core_addr;
	assign wr_data = i_loading ? i_load_data : i_core_wr_data;

	always_ff @(posedge clk) begin
		if (wr_en) begin
			// ROM is read only to the core
			if (i_loading && in_region(wr_addr, ROM_BASE, ROM_SIZE))
				rom[wr_addr[ROM_AW-1:0]] <= wr_data;
			if (in_region(wr_addr, EXT_RAM_BASE, EXT_RAM_SIZE))
				ext_ram[wr_addr[EXT_AW-1:0]] <= wr_data;
			if (in_region(wr_addr, STD_RAM_BASE, STD_RAM_SIZE))
				std_ram[wr_addr[STD_AW-1:0]] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		o_core_rd_data <= read_byte(i_core_addr);
		o_dbg_rd_data <= read_byte(i_dbg_addr);
	end

endmodule

// File: source/boot_control.sv
// Boot sequencer; a loader error is terminal until soft reset, and refresh is skipped while the display is busy
`timescale 1ns/1ns

module boot_control
	import mk14_pkg::*;
#(
	parameter int RX_TIMEOUT_CYCLES = 100_000_000,
	parameter int REFRESH_CYCLES = 2_500_000
) (
	input  logic       clk,
	input  logic       soft_reset,
	input  logic       i_rx_valid,
	input  logic       i_parse_complete,
	input  hex_error_t i_error,
	input  logic       i_display_idle,
	input  logic       i_reload,
	output logic       o_loading,
	output logic       o_core_en,
	output logic       o_refresh_strobe,
	output logic       o_load_error
);

	localparam int CNT_MAX = (RX_TIMEOUT_CYCLES > REFRESH_CYCLES) ? RX_TIMEOUT_CYCLES
			: REFRESH_CYCLES;
	localparam int CW = $clog2(CNT_MAX + 1);
	localparam logic [CW-1:0] RX_LOAD = CW'(RX_TIMEOUT_CYCLES);
	// Counting down to zero inclusive gives one strobe per REFRESH_CYCLES
	localparam logic [CW-1:0] REFRESH_LOAD = CW'(REFRESH_CYCLES - 1);

	boot_state_t state;
	// Receive timeout in RX_WAIT, refresh period in RUNNING
	logic [CW-1:0] count;

	always_ff @(posedge clk) begin
		o_refresh_strobe <= 1'b0;
		if (soft_reset) begin
			state <= BOOT_INIT;
			count <= '0;
		end else begin
			case (state)
				BOOT_INIT: begin
					count <= RX_LOAD;
					state <= BOOT_RX_WAIT;
				end
				BOOT_RX_WAIT: begin
					if (i_error != HEX_NONE)
						state <= BOOT_LOAD_ERROR;
					else if (i_parse_complete)
						state <= BOOT_START;
					else if (i_rx_valid)
						count <= RX_LOAD;
					else if (count == '0)
						state <= BOOT_START;
					else
						count <= count - 1'b1;
				end
				BOOT_START: begin
					count <= REFRESH_LOAD;
					state <= BOOT_RUNNING;
				end
				BOOT_RUNNING: begin
					if (i_reload) begin
						count <= RX_LOAD;
						state <= BOOT_RX_WAIT;
					end else if (count == '0) begin
						count <= REFRESH_LOAD;
						o_refresh_strobe <= i_display_idle;
					end else begin
						count <= count - 1'b1;
					end
				end
				BOOT_LOAD_ERROR: begin
					state <= BOOT_LOAD_ERROR;
				end
				default: state <= BOOT_INIT;
			endcase
		end
	end

	assign o_loading = (state == BOOT_RX_WAIT);
	assign o_core_en = (state == BOOT_RUNNING);
	assign o_load_error = (state == BOOT_LOAD_ERROR);

endmodule

// File: source/mk14_boot_soc.sv
// Boot and memory subsystem top; the core bus and display handshake are plain ports to external blocks
`timescale 1ns/1ns

module mk14_boot_soc
	import mk14_pkg::*;
#(
	parameter int CLKS_PER_BIT = 434,
	parameter int RX_TIMEOUT_CYCLES = 100_000_000,
	parameter int REFRESH_CYCLES = 2_500_000
) (
	input  logic        clk,
	input  logic        soft_reset,
	input  logic        i_rx,
	input  logic        i_reload,
	input  logic        i_display_idle,
	input  logic [11:0] i_core_addr,
	input  logic        i_core_wr_en,
	input  logic [7:0]  i_core_wr_data,
	input  logic [11:0] i_dbg_addr,
	output logic        o_rx_wait,
	output logic        o_core_en,
	output logic        o_refresh_strobe,
	output logic        o_load_error,
	output logic [7:0]  o_core_rd_data,
	output logic [7:0]  o_dbg_rd_data
);

	logic [7:0] rx_data;
	logic rx_valid;
	logic loading;
	logic hex_en;
	logic [11:0] hex_addr;
	logic [7:0] hex_data;
	logic hex_wr;
	logic parse_complete;
	hex_error_t hex_error;

	// Bytes reach the parser only while a load is in progress
	assign hex_en = rx_valid & loading;
	assign o_rx_wait = loading;

	uart_rx #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) u_uart_rx (
		.clk(clk),
		.soft_reset(soft_reset),
		.i_rx(i_rx),
		.o_rx_data(rx_data),
		.o_rx_valid(rx_valid)
	);

	intel_hex u_intel_hex (
		.clk(clk),
		.soft_reset(soft_reset),
		.i_en(hex_en),
		.i_data(rx_data),
		.o_wr_addr(hex_addr),
		.o_wr_data(hex_data),
		.o_wr_valid(hex_wr),
		.o_parse_complete(parse_complete),
		.o_error(hex_error),
		.o_idle()
	);

	memory_map u_memory_map (
		.clk(clk),
		.i_loading(loading),
		.i_load_addr(hex_addr),
		.i_load_data(hex_data),
		.i_load_wr(hex_wr),
		.i_core_addr(i_core_addr),
		.i_core_wr_en(i_core_wr_en),
		.i_core_wr_data(i_core_wr_data),
		.i_dbg_addr(i_dbg_addr),
		.o_core_rd_data(o_core_rd_data),
		.o_dbg_rd_data(o_dbg_rd_data)
	);

	boot_control #(
		.RX_TIMEOUT_CYCLES(RX_TIMEOUT_CYCLES),
		.REFRESH_CYCLES(REFRESH_CYCLES)
	) u_boot_control (
		.clk(clk),
		.soft_reset(soft_reset),
		.i_rx_valid(rx_valid),
		.i_parse_complete(parse_complete),
		.i_error(hex_error),
		.i_display_idle(i_display_idle),
		.i_reload(i_reload),
		.o_loading(loading),
		.o_core_en(o_core_en),
		.o_refresh_strobe(o_refresh_strobe),
		.o_load_error(o_load_error)
	);

endmodule

// File: verif/boot_checker.sv
// Samples the DUT on the falling edge; a testbench timeout counts as an error of the current test
`timescale 1ns/1ns

module boot_checker (
	input  logic       clk,
	input  logic       i_rx_wait,
	input  logic       i_core_en,
	input  logic       i_refresh_strobe,
	input  logic       i_load_error,
	input  logic [7:0] i_core_rd_data,
	input  logic [7:0] i_dbg_rd_data,
	input  logic       i_chk,
	input  logic [2:0] i_sel,
	input  logic [7:0] i_exp,
	input  logic       i_period_on,
	input  logic [7:0] i_period,
	input  logic       i_no_strobe,
	input  logic       i_done,
	input  logic [7:0] i_test,
	input  logic       i_summary,
	input  logic       i_timed_out,
	output int         o_errors
);

	int errors = 0;
	int checks = 0;
	int tests = 0;
	int test_start_errors = 0;
	int gap = 0;
	bit have_prev = 1'b0;
	logic [7:0] got;

	function automatic logic [7:0] observed(input logic [2:0] s);
		case (s)
			3'd0: return {7'd0, i_rx_wait};
			3'd1: return {7'd0, i_core_en};
			3'd2: return {7'd0, i_refresh_strobe};
			3'd3: return {7'd0, i_load_error};
			3'd4: return i_core_rd_data;
			default: return i_dbg_rd_data;
		endcase
	endfunction

	function automatic string sig_name(input logic [2:0] s);
		case (s)
			3'd0: return "o_rx_wait";
			3'd1: return "o_core_en";
			3'd2: return "o_refresh_strobe";
			3'd3: return "o_load_error";
			3'd4: return "o_core_rd_data";
			default: return "o_dbg_rd_data";
		endcase
	endfunction

	always @(negedge clk) begin
		if (i_chk) begin
			got = observed(i_sel);
			checks++;
			if (got !== i_exp) begin
				$display("Mismatch test %0d %s: got %h expected %h", i_test, sig_name(i_sel),
						got, i_exp);
				errors++;
			end
		end

		// Strobe spacing is measured only between two strobes seen while enabled
		if (!i_period_on) begin
			have_prev = 1'b0;
		end else if (i_refresh_strobe) begin
			if (have_prev && (gap + 1 > i_period + 1 || gap + 1 < i_period - 1)) begin
				$display("Test %0d: refresh strobes were %0d cycles apart instead of %0d",
						i_test, gap + 1, i_period);
				errors++;
			end
			have_prev = 1'b1;
		end
		gap = i_refresh_strobe ? 0 : gap + 1;

		if (i_no_strobe && i_refresh_strobe) begin
			$display("Test %0d: refresh strobe appeared while the display was busy", i_test);
			errors++;
		end

		if (i_done) begin
			tests++;
			// A wait that ran out of time fails the test it belongs to
			if (i_timed_out)
				errors++;
			if (errors == test_start_errors)
				$display("Test %0d passed", i_test);
			else
				$display("Test %0d failed with %0d errors", i_test, errors - test_start_errors);
			test_start_errors = errors;
		end

		if (i_summary)
			$display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
		o_errors = errors;
	end

endmodule

// File: verif/tb_mk14_boot_soc.sv
// Testbench top; UART frames are driven at CLKS_PER_BIT 4, and loaded data comes from a fixed seed
`timescale 1ns/1ns

module tb_mk14_boot_soc;
	import mk14_pkg::*;

	localparam int CLKS_PER_BIT = 4;
	localparam int RX_TIMEOUT_CYCLES = 2000;
	localparam int REFRESH_CYCLES = 16;
	localparam int N_MAX = 32;

	// Test kinds
	localparam logic [3:0] K_RESET = 4'd0, K_LOAD = 4'd1, K_DBG = 4'd2, K_CORE_OFF = 4'd3;
	localparam logic [3:0] K_EOF = 4'd4, K_CWR = 4'd5, K_CRD = 4'd6, K_REFRESH = 4'd7;
	localparam logic [3:0] K_NO_REFRESH = 4'd8, K_RELOAD = 4'd9, K_BAD_LOAD = 4'd10;
	localparam logic [3:0] K_RX_TIMEOUT = 4'd11;

	// Checker signal selects
	localparam logic [2:0] S_RX_WAIT = 3'd0, S_CORE_EN = 3'd1, S_STROBE = 3'd2;
	localparam logic [2:0] S_LOAD_ERR = 3'd3, S_CORE_RD = 3'd4, S_DBG_RD = 3'd5;

	logic clk, soft_reset, rx, reload, display_idle, core_wr_en;
	logic [11:0] core_addr, dbg_addr;
	logic [7:0] core_wr_data;
	logic rx_wait, core_en, refresh_strobe, load_error;
	logic [7:0] core_rd_data, dbg_rd_data;

	logic chk, period_on, no_strobe, done, summary;
	logic [2:0] sel;
	logic [7:0] exp_val, test_id;
	int errors;

	logic [3:0] t_kind [N_MAX];
	logic [11:0] t_addr [N_MAX];
	logic [7:0] t_data [N_MAX];
	int n_tests;
	logic [7:0] model [0:4095];
	int seed;
	bit timed_out;

	mk14_boot_soc #(
		.CLKS_PER_BIT(CLKS_PER_BIT),
		.RX_TIMEOUT_CYCLES(RX_TIMEOUT_CYCLES),
		.REFRESH_CYCLES(REFRESH_CYCLES)
	) DUT (
		.clk(clk),
		.soft_reset(soft_reset),
		.i_rx(rx),
		.i_reload(reload),
		.i_display_idle(display_idle),
		.i_core_addr(core_addr),
		.i_core_wr_en(core_wr_en),
		.i_core_wr_data(core_wr_data),
		.i_dbg_addr(dbg_addr),
		.o_rx_wait(rx_wait),
		.o_core_en(core_en),
		.o_refresh_strobe(refresh_strobe),
		.o_load_error(load_error),
		.o_core_rd_data(core_rd_data),
		.o_dbg_rd_data(dbg_rd_data)
	);

	boot_checker u_checker (
		.clk(clk),
		.i_rx_wait(rx_wait),
		.i_core_en(core_en),
		.i_refresh_strobe(refresh_strobe),
		.i_load_error(load_error),
		.i_core_rd_data(core_rd_data),
		.i_dbg_rd_data(dbg_rd_data),
		.i_chk(chk),
		.i_sel(sel),
		.i_exp(exp_val),
		.i_period_on(period_on),
		.i_period(8'(REFRESH_CYCLES)),
		.i_no_strobe(no_strobe),
		.i_done(done),
		.i_test(test_id),
		.i_summary(summary),
		.i_timed_out(timed_out),
		.o_errors(errors)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic add_test(input logic [3:0] k, input logic [11:0] a, input logic [7:0] d);
		t_kind[n_tests] = k;
		t_addr[n_tests] = a;
		t_data[n_tests] = d;
		n_tests++;
	endtask

	function automatic logic [7:0] hex_char(input logic [3:0] n);
		return (n < 4'd10) ? 8'h30 + {4'h0, n} : 8'h37 + {4'h0, n};
	endfunction

	// Start bit, eight data bits LSB first, stop bit, then one idle bit
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge clk) rx <= frame[i];
			repeat (CLKS_PER_BIT - 1) @(posedge clk);
		end
		repeat (CLKS_PER_BIT) @(posedge clk);
	endtask

	task automatic send_hex(input logic [7:0] b);
		send_byte(hex_char(b[7:4]));
		send_byte(hex_char(b[3:0]));
	endtask

	// One record of zero or one data byte; bad adds one to the checksum
	task automatic send_record(input logic [15:0] a, input logic [7:0] cnt,
			input logic [7:0] typ, input logic [7:0] d, input bit bad);
		logic [7:0] sum;
		sum = cnt + a[15:8] + a[7:0] + typ + ((cnt != 8'd0) ? d : 8'd0);
		send_byte(":");
		send_hex(cnt);
		send_hex(a[15:8]);
		send_hex(a[7:0]);
		send_hex(typ);
		if (cnt != 8'd0)
			send_hex(d);
		send_hex(8'(-sum) + {7'd0, bad});
		send_byte(8'h0D);
		send_byte(8'h0A);
	endtask

	function automatic logic flag_value(input logic [2:0] s);
		case (s)
			S_RX_WAIT: return rx_wait;
			S_CORE_EN: return core_en;
			S_STROBE: return refresh_strobe;
			default: return load_error;
		endcase
	endfunction

	function automatic logic is_ram(input logic [11:0] a);
		return (a >= EXT_RAM_BASE && a < EXT_RAM_BASE + EXT_RAM_SIZE) || (a >= STD_RAM_BASE);
	endfunction

	function automatic logic [7:0] expected_read(input logic [11:0] a);
		if (a < ROM_BASE + ROM_SIZE || is_ram(a))
			return model[a];
		return UNMAPPED_DATA;
	endfunction

	task automatic check(input logic [2:0] s, input logic [7:0] e);
		@(posedge clk);
		chk <= 1'b1;
		sel <= s;
		exp_val <= e;
		@(posedge clk) chk <= 1'b0;
	endtask

	task automatic wait_for(input logic [2:0] s, input logic v, input int limit,
			input string what);
		int n;
		n = 0;
		@(negedge clk);
		while (flag_value(s) != v && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (flag_value(s) != v) begin
			$display("Timeout after %0d cycles waiting for %s", limit, what);
			timed_out = 1'b1;
		end
	endtask

	task automatic run_test(input logic [3:0] k, input logic [11:0] a, input logic [7:0] d);
		logic [7:0] b;
		case (k)
			K_RESET: begin
				@(posedge clk) soft_reset <= 1'b1;
				repeat (2) @(posedge clk);
				soft_reset <= 1'b0;
				wait_for(S_RX_WAIT, 1'b1, 20, "o_rx_wait after reset");
				check(S_CORE_EN, 8'd0);
				check(S_STROBE, 8'd0);
				check(S_RX_WAIT, 8'd1);
				check(S_LOAD_ERR, 8'd0);
			end
			K_LOAD: begin
				b = 8'($random(seed));
				model[a] = b;
				send_record({4'h0, a}, 8'd1, 8'h00, b, 1'b0);
			end
			K_DBG: begin
				@(posedge clk) dbg_addr <= a;
				check(S_DBG_RD, expected_read(a));
			end
			K_CORE_OFF: begin
				check(S_CORE_EN, 8'd0);
				check(S_RX_WAIT, 8'd1);
			end
			K_EOF: begin
				send_record(16'h0000, 8'd0, 8'h01, 8'h00, 1'b0);
				wait_for(S_CORE_EN, 1'b1, 50, "o_core_en after end-of-file record");
				check(S_RX_WAIT, 8'd0);
			end
			K_CWR: begin
				@(posedge clk);
				core_addr <= a;
				core_wr_data <= d;
				core_wr_en <= 1'b1;
				@(posedge clk) core_wr_en <= 1'b0;
				if (is_ram(a))
					model[a] = d;
			end
			K_CRD: begin
				@(posedge clk) core_addr <= a;
				check(S_CORE_RD, expected_read(a));
			end
			K_REFRESH: begin
				@(posedge clk);
				display_idle <= 1'b1;
				period_on <= 1'b1;
				for (int i = 0; i < 4 && !timed_out; i++)
					wait_for(S_STROBE, 1'b1, 2 * REFRESH_CYCLES, "refresh strobe");
				@(posedge clk) period_on <= 1'b0;
			end
			K_NO_REFRESH: begin
				@(posedge clk) display_idle <= 1'b0;
				repeat (2) @(posedge clk);
				no_strobe <= 1'b1;
				repeat (5 * REFRESH_CYCLES) @(posedge clk);
				no_strobe <= 1'b0;
				check(S_CORE_EN, 8'd1);
			end
			K_RELOAD: begin
				@(posedge clk) reload <= 1'b1;
				@(posedge clk) reload <= 1'b0;
				wait_for(S_CORE_EN, 1'b0, 10, "o_core_en to drop after reload");
				check(S_RX_WAIT, 8'd1);
			end
			K_BAD_LOAD: begin
				send_record({4'h0, a}, 8'd1, 8'h00, d, 1'b1);
				wait_for(S_LOAD_ERR, 1'b1, 50, "o_load_error after bad checksum");
				check(S_CORE_EN, 8'd0);
			end
			default: begin
				wait_for(S_CORE_EN, 1'b1, RX_TIMEOUT_CYCLES + 500, "receive timeout start");
				check(S_RX_WAIT, 8'd0);
			end
		endcase
	endtask

	initial begin
		soft_reset = 1'b0;
		rx = 1'b1;
		reload = 1'b0;
		display_idle = 1'b0;
		core_addr = '0;
		core_wr_en = 1'b0;
		core_wr_data = '0;
		dbg_addr = '0;
		chk = 1'b0;
		sel = '0;
		exp_val = '0;
		period_on = 1'b0;
		no_strobe = 1'b0;
		done = 1'b0;
		summary = 1'b0;
		test_id = '0;
		seed = 32'h25fecfc2;
		timed_out = 1'b0;
		n_tests = 0;

		add_test(K_RESET, 12'h000, 8'h00);
		add_test(K_LOAD, 12'h000, 8'h00);
		add_test(K_LOAD, 12'h1FF, 8'h00);
		add_test(K_LOAD, 12'hB05, 8'h00);
		add_test(K_LOAD, 12'hF10, 8'h00);
		add_test(K_CORE_OFF, 12'h000, 8'h00);
		add_test(K_DBG, 12'h000, 8'h00);
		add_test(K_DBG, 12'h1FF, 8'h00);
		add_test(K_DBG, 12'hB05, 8'h00);
		add_test(K_DBG, 12'hF10, 8'h00);
		add_test(K_EOF, 12'h000, 8'h00);
		add_test(K_CWR, 12'hB05, 8'h5A);
		add_test(K_CRD, 12'hB05, 8'h00);
		add_test(K_CWR, 12'hF10, 8'hA5);
		add_test(K_CRD, 12'hF10, 8'h00);
		add_test(K_CWR, 12'h000, 8'h77);
		add_test(K_CRD, 12'h000, 8'h00);
		add_test(K_CRD, 12'h800, 8'h00);
		add_test(K_REFRESH, 12'h000, 8'h00);
		add_test(K_NO_REFRESH, 12'h000, 8'h00);
		add_test(K_RELOAD, 12'h000, 8'h00);
		add_test(K_BAD_LOAD, 12'h020, 8'h3C);
		add_test(K_RESET, 12'h000, 8'h00);
		add_test(K_LOAD, 12'hF20, 8'h00);
		add_test(K_RX_TIMEOUT, 12'h000, 8'h00);
		add_test(K_DBG, 12'hF20, 8'h00);

		for (int t = 0; t < n_tests && !timed_out; t++) begin
			@(posedge clk) test_id <= 8'(t);
			run_test(t_kind[t], t_addr[t], t_data[t]);
			@(posedge clk) done <= 1'b1;
			@(posedge clk) done <= 1'b0;
		end
		@(posedge clk) summary <= 1'b1;
		@(posedge clk) summary <= 1'b0;
		@(negedge clk);
		if (timed_out || errors != 0)
			$display("FAIL: see errors above");
		else
			$display("PASS: all tests");
		$finish;
	end

endmodule

// File: project.f
common/mk14_pkg.sv
source/uart_rx.sv
intel_hex/intel_hex.sv
source/memory_map.sv
source/boot_control.sv
source/mk14_boot_soc.sv
verif/boot_checker.sv
verif/tb_mk14_boot_soc.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it into sim.log and fails on the fail message
verilator --binary --timing -Wno-fatal -f project.f --top-module tb_mk14_boot_soc \
	-o tb_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1; cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1
grep -q "PASS: all tests" sim.log && exit 0 || exit 1
